//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module tb_a23_gc_main -f a23_gc.f
	out="$$(./obj_dir/Vtb_a23_gc_main)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

//--- a23_gc.f
rtl/a23_gc_pkg.sv
rtl/a23_regfile.sv
rtl/a23_core.sv
rtl/a23_mem.sv
rtl/a23_gc_main.sv
sim/a23_gc_checker.sv
sim/tb_a23_gc_main.sv

//--- rtl/a23_core.sv
module a23_core (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  output logic [31:0]                    o_m_address,
  output logic [31:0]                    o_m_write,
  output logic                           o_m_write_en,
  input  logic [31:0]                    i_m_read,
  output logic [a23_gc_pkg::REG_AW-1:0]  o_rf_ra,
  output logic [a23_gc_pkg::REG_AW-1:0]  o_rf_rb,
  input  logic [31:0]                    i_rf_da,
  input  logic [31:0]                    i_rf_db,
  output logic [a23_gc_pkg::REG_AW-1:0]  o_rf_wa,
  output logic [31:0]                    o_rf_wd,
  output logic                           o_rf_we,
  output logic                           o_terminate
);

  import a23_gc_pkg::*;

  core_state_e        state;
  core_state_e        state_nxt;
  logic [31:0]        pc;
  logic [31:0]        pc_nxt;
  logic [31:0]        ir;
  logic [31:0]        instr;
  opcode_e            opcode;
  logic [REG_AW-1:0]  rd;
  logic [REG_AW-1:0]  rn;
  logic [REG_AW-1:0]  rm;
  logic [31:0]        imm;
  logic [31:0]        alu_out;
  logic [31:0]        data_addr;
  logic               is_mem_op;
  logic               terminate;

  // Fetched word arrives during EXEC, later states use the latched copy
  assign instr  = (state == ST_EXEC) ? i_m_read : ir;
  assign opcode = opcode_e'(instr[OPC_MSB:OPC_LSB]);
  assign rd     = instr[RD_LSB +: REG_AW];
  assign rn     = instr[RN_LSB +: REG_AW];
  assign rm     = instr[RM_LSB +: REG_AW];
  assign imm    = {16'd0, instr[IMM_MSB:IMM_LSB]};

  assign is_mem_op = (opcode == OP_LDR) || (opcode == OP_STR);
  assign data_addr = i_rf_da + imm;

  // BNZ tests rd on port a, STR sends rd out on port b
  assign o_rf_ra = (opcode == OP_BNZ) ? rd : rn;
  assign o_rf_rb = (opcode == OP_STR) ? rd : rm;

  always_comb begin
    case (opcode)
      OP_ADD:  alu_out = i_rf_da + i_rf_db;
      OP_SUB:  alu_out = i_rf_da - i_rf_db;
      OP_AND:  alu_out = i_rf_da & i_rf_db;
      OP_XOR:  alu_out = i_rf_da ^ i_rf_db;
      default: alu_out = imm;  // MOVI
    endcase
  end

  assign o_m_address  = (state == ST_EXEC && is_mem_op) ? data_addr : pc;
  assign o_m_write    = i_rf_db;
  assign o_m_write_en = (state == ST_EXEC) && (opcode == OP_STR);

  always_comb begin
    o_rf_wa = rd;
    o_rf_wd = alu_out;
    o_rf_we = 1'b0;
    if (state == ST_EXEC) begin
      case (opcode)
        OP_MOVI, OP_ADD, OP_SUB, OP_AND, OP_XOR: o_rf_we = 1'b1;
        default: o_rf_we = 1'b0;
      endcase
    end else if (state == ST_MEM && opcode == OP_LDR) begin
      o_rf_wd = i_m_read;  // Load data from address presented in EXEC
      o_rf_we = 1'b1;
    end
  end

  always_comb begin
    state_nxt = state;
    pc_nxt    = pc;
    case (state)
      ST_FETCH: state_nxt = ST_EXEC;
      ST_EXEC: begin
        state_nxt = ST_FETCH;
        pc_nxt    = pc + 32'd4;
        case (opcode)
          OP_LDR, OP_STR: state_nxt = ST_MEM;
          OP_BNZ: begin
            if (i_rf_da != 32'd0) begin
              pc_nxt = {14'd0, instr[IMM_MSB:IMM_LSB], 2'b00};
            end
          end
          OP_HALT: begin
            state_nxt = ST_HALT;
            pc_nxt    = pc;
          end
          default: state_nxt = ST_FETCH;
        endcase
      end
      ST_MEM:  state_nxt = ST_FETCH;
      default: state_nxt = ST_HALT;  // Held until reset
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state     <= ST_FETCH;
      pc        <= 32'd0;
      ir        <= 32'd0;
      terminate <= 1'b0;
    end else begin
      state <= state_nxt;
      pc    <= pc_nxt;
      if (state == ST_EXEC) begin
        ir <= i_m_read;
      end
      if (state == ST_HALT) begin
        terminate <= 1'b1;  // Sticky
      end
    end
  end

  assign o_terminate = terminate;

endmodule

//--- rtl/a23_gc_main.sv
module a23_gc_main (
  input  logic  i_clk,
  input  logic  i_rst_n,
  input  logic [32*(a23_gc_pkg::CODE_MEM_SIZE+a23_gc_pkg::G_MEM_SIZE)-1:0]  i_g_init,
  input  logic [32*a23_gc_pkg::E_MEM_SIZE-1:0]                              i_e_init,
  output logic [32*a23_gc_pkg::OUT_MEM_SIZE-1:0]                            o_out,
  output logic  o_terminate
);

  import a23_gc_pkg::*;

  logic [32*CODE_MEM_SIZE-1:0] p_init;
  logic [32*G_MEM_SIZE-1:0]    g_init;

  logic [31:0]        m_address;
  logic [31:0]        m_write;
  logic               m_write_en;
  logic [31:0]        m_read;
  logic [REG_AW-1:0]  rf_ra;
  logic [REG_AW-1:0]  rf_rb;
  logic [31:0]        rf_da;
  logic [31:0]        rf_db;
  logic [REG_AW-1:0]  rf_wa;
  logic [31:0]        rf_wd;
  logic               rf_we;

  assign p_init = i_g_init[32*(CODE_MEM_SIZE+G_MEM_SIZE)-1 : 32*G_MEM_SIZE];  // Program
  assign g_init = i_g_init[32*G_MEM_SIZE-1:0];  // Garbler inputs

  a23_core u_a23_core (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .o_m_address  (m_address),
    .o_m_write    (m_write),
    .o_m_write_en (m_write_en),
    .i_m_read     (m_read),
    .o_rf_ra      (rf_ra),
    .o_rf_rb      (rf_rb),
    .i_rf_da      (rf_da),
    .i_rf_db      (rf_db),
    .o_rf_wa      (rf_wa),
    .o_rf_wd      (rf_wd),
    .o_rf_we      (rf_we),
    .o_terminate  (o_terminate)
  );

  a23_regfile u_a23_regfile (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_ra    (rf_ra),
    .i_rb    (rf_rb),
    .o_da    (rf_da),
    .o_db    (rf_db),
    .i_wa    (rf_wa),
    .i_wd    (rf_wd),
    .i_we    (rf_we)
  );

  a23_mem u_a23_mem (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_p_init     (p_init),
    .i_g_init     (g_init),
    .i_e_init     (i_e_init),
    .o_out        (o_out),
    .i_m_address  (m_address),
    .i_m_write    (m_write),
    .i_m_write_en (m_write_en),
    .o_m_read     (m_read)
  );

endmodule

//--- rtl/a23_gc_pkg.sv
package a23_gc_pkg;

  // Region sizes in 32-bit words
  localparam int CODE_MEM_SIZE  = 16;
  localparam int G_MEM_SIZE     = 16;
  localparam int E_MEM_SIZE     = 16;
  localparam int OUT_MEM_SIZE   = 16;
  localparam int STACK_MEM_SIZE = 16;

  // Region select lives in address bits 26:24
  localparam int REGION_MSB = 26;
  localparam int REGION_LSB = 24;

  localparam logic [2:0] REGION_CODE  = 3'd0;  // 0x00000000
  localparam logic [2:0] REGION_G     = 3'd1;  // 0x01000000
  localparam logic [2:0] REGION_E     = 3'd2;  // 0x02000000
  localparam logic [2:0] REGION_OUT   = 3'd3;  // 0x03000000
  localparam logic [2:0] REGION_STACK = 3'd4;  // 0x04000000

  // Word index within a region
  localparam int WORD_IDX_MSB = 5;
  localparam int WORD_IDX_LSB = 2;

  localparam int NUM_REGS = 8;
  localparam int REG_AW   = $clog2(NUM_REGS);

  // Instruction fields
  localparam int OPC_MSB = 31;
  localparam int OPC_LSB = 28;
  localparam int RD_LSB  = 24;  // Only low REG_AW bits used
  localparam int RN_LSB  = 20;
  localparam int RM_LSB  = 16;
  localparam int IMM_MSB = 15;
  localparam int IMM_LSB = 0;

  typedef enum logic [3:0] {
    OP_NOP  = 4'h0,
    OP_MOVI = 4'h1,
    OP_ADD  = 4'h2,
    OP_SUB  = 4'h3,
    OP_AND  = 4'h4,
    OP_XOR  = 4'h5,
    OP_LDR  = 4'h6,
    OP_STR  = 4'h7,
    OP_BNZ  = 4'h8,
    OP_HALT = 4'h9
  } opcode_e;

  typedef enum logic [1:0] {
    ST_FETCH = 2'd0,
    ST_EXEC  = 2'd1,
    ST_MEM   = 2'd2,
    ST_HALT  = 2'd3
  } core_state_e;

endpackage

//--- rtl/a23_mem.sv
module a23_mem (
  input  logic                                      i_clk,
  input  logic                                      i_rst_n,
  input  logic [32*a23_gc_pkg::CODE_MEM_SIZE-1:0]   i_p_init,
  input  logic [32*a23_gc_pkg::G_MEM_SIZE-1:0]      i_g_init,
  input  logic [32*a23_gc_pkg::E_MEM_SIZE-1:0]      i_e_init,
  output logic [32*a23_gc_pkg::OUT_MEM_SIZE-1:0]    o_out,
  input  logic [31:0]                               i_m_address,
  input  logic [31:0]                               i_m_write,
  input  logic                                      i_m_write_en,
  output logic [31:0]                               o_m_read
);

  import a23_gc_pkg::*;

  logic [31:0] code_mem  [CODE_MEM_SIZE];
  logic [31:0] g_mem     [G_MEM_SIZE];
  logic [31:0] e_mem     [E_MEM_SIZE];
  logic [31:0] out_mem   [OUT_MEM_SIZE];
  logic [31:0] stack_mem [STACK_MEM_SIZE];

  logic [2:0]  region;
  logic [WORD_IDX_MSB-WORD_IDX_LSB:0] idx;

  assign region = i_m_address[REGION_MSB:REGION_LSB];
  assign idx    = i_m_address[WORD_IDX_MSB:WORD_IDX_LSB];

  // Read-only regions take the init vectors while reset is held
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < CODE_MEM_SIZE; i++) begin
        code_mem[i] <= i_p_init[i*32 +: 32];
      end
      for (int i = 0; i < G_MEM_SIZE; i++) begin
        g_mem[i] <= i_g_init[i*32 +: 32];
      end
      for (int i = 0; i < E_MEM_SIZE; i++) begin
        e_mem[i] <= i_e_init[i*32 +: 32];
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < OUT_MEM_SIZE; i++) begin
        out_mem[i] <= 32'd0;
      end
      for (int i = 0; i < STACK_MEM_SIZE; i++) begin
        stack_mem[i] <= 32'd0;
      end
    end else if (i_m_write_en) begin
      if (region == REGION_OUT) begin
        out_mem[idx] <= i_m_write;
      end else if (region == REGION_STACK) begin
        stack_mem[idx] <= i_m_write;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    case (region)
      REGION_CODE:  o_m_read <= code_mem[idx];
      REGION_G:     o_m_read <= g_mem[idx];
      REGION_E:     o_m_read <= e_mem[idx];
      REGION_OUT:   o_m_read <= out_mem[idx];
      REGION_STACK: o_m_read <= stack_mem[idx];
      default:      o_m_read <= 32'd0;  // Unmapped
    endcase
  end

  always_comb begin
    for (int i = 0; i < OUT_MEM_SIZE; i++) begin
      o_out[i*32 +: 32] = out_mem[i];  // Word 0 in low bits
    end
  end

endmodule

//--- rtl/a23_regfile.sv
module a23_regfile (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic [a23_gc_pkg::REG_AW-1:0]  i_ra,
  input  logic [a23_gc_pkg::REG_AW-1:0]  i_rb,
  output logic [31:0]                    o_da,
  output logic [31:0]                    o_db,
  input  logic [a23_gc_pkg::REG_AW-1:0]  i_wa,
  input  logic [31:0]                    i_wd,
  input  logic                           i_we
);

  import a23_gc_pkg::*;

  logic [31:0] regs [NUM_REGS];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (i_we) begin
      regs[i_wa] <= i_wd;
    end
  end

  // Asynchronous reads, no write bypass
  assign o_da = regs[i_ra];
  assign o_db = regs[i_rb];

endmodule

//--- sim/a23_gc_checker.sv
module a23_gc_checker (
  input logic                     i_clk,
  input logic                     i_rst_n,
  input a23_gc_pkg::core_state_e  i_state,
  input logic                     i_write_en,
  input logic                     i_terminate
);

  import a23_gc_pkg::*;

  int fail_count = 0;

  terminate_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !$fell(i_terminate))
    else begin
      fail_count++;
      $error("o_terminate fell while out of reset");
    end

  write_in_exec: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_write_en |-> (i_state == ST_EXEC))
    else begin
      fail_count++;
      $error("o_m_write_en high outside ST_EXEC");
    end

  no_write_after_halt: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_terminate |-> !i_write_en)
    else begin
      fail_count++;
      $error("bus write after terminate");
    end

  fetch_after_reset: assert property (@(posedge i_clk)
    $rose(i_rst_n) |-> (i_state == ST_FETCH))
    else begin
      fail_count++;
      $error("core not in ST_FETCH after reset release");
    end

endmodule

bind a23_core a23_gc_checker chk_i (
  .i_clk       (i_clk),
  .i_rst_n     (i_rst_n),
  .i_state     (state),
  .i_write_en  (o_m_write_en),
  .i_terminate (o_terminate)
);

//--- sim/a23_gc_golden.hex
// 64 words: 16 program, 16 garbler inputs, 16 evaluator inputs, 16 expected outputs
// Program words 0 to 15
61000000 62100000 23110000 64300000
26130000 55240000 75600000 47240000
20020000 32270000 82000008 70600004
70300004 65300004 75600008 90000000
// Garbler words 0 to 15
00000005 11110001 11110002 11110003
11110004 11110005 11110006 11110007
11110008 11110009 1111000a 1111000b
1111000c 1111000d 1111000e 1111000f
// Evaluator words 0 to 15
00000013 cafef00d 22220002 22220003
22220004 22220005 22220006 22220007
22220008 22220009 2222000a 2222000b
2222000c 2222000d 2222000e 2222000f
// Expected output words 0 to 15
00000016 0000000f cafef00d 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000

//--- sim/tb_a23_gc_main.sv
module tb_a23_gc_main;

  import a23_gc_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int HOLD_CYCLES    = 20;
  localparam int G_BASE         = CODE_MEM_SIZE;
  localparam int E_BASE         = CODE_MEM_SIZE + G_MEM_SIZE;
  localparam int OUT_BASE       = CODE_MEM_SIZE + G_MEM_SIZE + E_MEM_SIZE;
  localparam int GOLDEN_WORDS   = OUT_BASE + OUT_MEM_SIZE;

  logic                                     clk;
  logic                                     rst_n;
  logic [32*(CODE_MEM_SIZE+G_MEM_SIZE)-1:0] g_init;
  logic [32*E_MEM_SIZE-1:0]                 e_init;
  logic [32*OUT_MEM_SIZE-1:0]               out;
  logic                                     terminate;

  logic [31:0] golden [GOLDEN_WORDS];
  int          cycles;

  a23_gc_main dut_i (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_g_init    (g_init),
    .i_e_init    (e_init),
    .o_out       (out),
    .o_terminate (terminate)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error: time %0t %s expected %08h actual %08h", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // Output region must read back as all zero
  task automatic check_out_clear();
    for (int i = 0; i < OUT_MEM_SIZE; i++) begin
      check_value($sformatf("o_out[%0d]", i), 32'd0, out[i*32 +: 32]);
    end
    check_value("o_terminate", 32'd0, {31'd0, terminate});
  endtask

  task automatic load_init_vectors();
    for (int i = 0; i < CODE_MEM_SIZE; i++) begin
      g_init[32*G_MEM_SIZE + 32*i +: 32] = golden[i];  // Program in upper bits
    end
    for (int i = 0; i < G_MEM_SIZE; i++) begin
      g_init[32*i +: 32] = golden[G_BASE + i];
    end
    for (int i = 0; i < E_MEM_SIZE; i++) begin
      e_init[32*i +: 32] = golden[E_BASE + i];
    end
  endtask

  always @(dut_i.u_a23_core.chk_i.fail_count) begin
    if (dut_i.u_a23_core.chk_i.fail_count != 0) begin
      $display("Bus checker assertion failed at time %0t", $time);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  initial begin
    rst_n  = 1'b0;
    g_init = '0;
    e_init = '0;
    cycles = 0;
    $readmemh("sim/a23_gc_golden.hex", golden);

    @(negedge clk);
    load_init_vectors();
    repeat (2) begin
      @(negedge clk);
    end
    check_out_clear();  // Still in reset
    rst_n = 1'b1;

    @(negedge clk);
    check_out_clear();

    while (!terminate && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (!terminate) begin
      $display("Timed out after %0d cycles waiting for o_terminate", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $fatal(1);
    end

    // Terminate is sticky
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      check_value("o_terminate", 32'd1, {31'd0, terminate});
    end

    for (int i = 0; i < OUT_MEM_SIZE; i++) begin
      check_value($sformatf("o_out[%0d]", i), golden[OUT_BASE + i], out[i*32 +: 32]);
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule
